// File: design/rom_word_pkg.sv
// Byte, word and address types passed between the loader stages and the ROM banks
package rom_word_pkg;

	// ########################################
	// Download side
	// ########################################

	typedef logic [7:0]  byte_t;		// One byte from the host
	typedef logic [24:0] dl_addr_t;		// Byte address of the download stream
	typedef logic [15:0] dl_index_t;	// File index, 0 is the ROM set

	// ########################################
	// Word sizes per region
	// ########################################

	typedef logic [15:0] prog_word_t;	// Main CPU bus width
	typedef logic [31:0] gfx_word_t;	// Four graphics planes side by side

	// ########################################
	// Game side addresses
	// ########################################

	// Program word address, 68010 byte address without bit 0
	typedef logic [18:0] prog_addr_t;
	typedef logic [15:0] snd_addr_t;	// Audio CPU space, 16S and 16R together
	typedef logic [13:0] chr_addr_t;	// Alphanumerics ROM

	// External memory word address
	typedef logic [22:0] gfx_addr_t;	// Byte address over 4

endpackage

// File: design/rom_map_pkg.sv
// Board ROM map, used by the address decoder and the program and sound stores
package rom_map_pkg;

	// Where a download byte belongs
	typedef enum logic [2:0] {
		reg_none,	// Filler or past the end of the map
		reg_gfx,	// Graphics to external memory
		reg_prog,	// Main CPU program
		reg_snd,	// Audio CPU program
		reg_chr		// Alphanumerics
	} region_t;

	typedef logic [2:0] prog_bank_t;	// 0 to 5

	// ########################################
	// Download windows, byte addresses
	// ########################################

	localparam rom_word_pkg::dl_addr_t GFX_END = 25'h0C0000;	// Six groups of 4x32 KB

	localparam int PROG_BANKS = 6;

	// Each window holds an even and an odd ROM interleaved
	localparam rom_word_pkg::dl_addr_t PROG_WIN_BASE [PROG_BANKS] = '{
		25'h0C0000,	// 9A 9B
		25'h0F0000,	// 10A 10B half size
		25'h100000,	// 7A 7B
		25'h110000,	// 6A 6B
		25'h120000,	// 5A 5B
		25'h130000	// 3A 3B
	};
	localparam int PROG_BANK_AW [PROG_BANKS] = '{15, 14, 15, 15, 15, 15};	// Word address bits

	localparam rom_word_pkg::dl_addr_t SND_S_BASE = 25'h140000;
	localparam int SND_S_AW = 15;	// 32 KB
	localparam rom_word_pkg::dl_addr_t SND_R_BASE = 25'h148000;
	localparam int SND_R_AW = 14;	// 16 KB
	localparam rom_word_pkg::dl_addr_t CHR_BASE = 25'h14C000;
	localparam int CHR_AW = 14;	// 16 KB

	// ########################################
	// Game side program windows, word addresses
	// ########################################

	localparam rom_word_pkg::prog_addr_t PROG_GAME_BASE [PROG_BANKS] = '{
		19'h00000, 19'h18000, 19'h20000, 19'h28000, 19'h30000, 19'h38000
	};
	localparam int PROG_SEL_LSB = 14;	// Lowest bit that picks a window

endpackage

// File: design/load_decode.sv
// First loader stage, registers each accepted download byte and tags it with its ROM region
`timescale 1ns/10ps

module load_decode (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      dl_active,
	input  logic                      dl_wr,		// One cycle per byte
	input  rom_word_pkg::dl_index_t   dl_index,
	input  rom_word_pkg::dl_addr_t    dl_addr,
	input  rom_word_pkg::byte_t       dl_data,
	output logic                      byte_vld,
	output rom_map_pkg::region_t      byte_region,
	output rom_map_pkg::prog_bank_t   byte_bank,
	output rom_word_pkg::dl_addr_t    byte_addr,
	output rom_word_pkg::byte_t       byte_data,
	output logic                      word_end	// Last byte of a word
);
	import rom_word_pkg::*;
	import rom_map_pkg::*;

	logic       accept;
	region_t    region_nxt;
	prog_bank_t bank_nxt;
	logic       word_end_nxt;

	// True when base <= a < base + 2**aw
	function automatic logic in_window(dl_addr_t a, dl_addr_t base, int aw);
		dl_addr_t size;
		size = dl_addr_t'(1) << aw;
		return (a >= base) && (a < base + size);
	endfunction

	assign accept = dl_wr && dl_active && (dl_index == '0);	// ROM set only

	// ########################################
	// Map decode
	// ########################################

	always_comb begin
		region_nxt = reg_none;	// Filler unless a window matches
		bank_nxt   = '0;
		if (dl_addr < GFX_END) begin
			region_nxt = reg_gfx;
		end
		for (int b = 0; b < PROG_BANKS; b++) begin
			// Byte window is twice the word depth
			if (in_window(dl_addr, PROG_WIN_BASE[b], PROG_BANK_AW[b] + 1)) begin
				region_nxt = reg_prog;
				bank_nxt   = prog_bank_t'(b);
			end
		end
		if (in_window(dl_addr, SND_S_BASE, SND_S_AW) || in_window(dl_addr, SND_R_BASE, SND_R_AW)) begin
			region_nxt = reg_snd;
		end
		if (in_window(dl_addr, CHR_BASE, CHR_AW)) begin
			region_nxt = reg_chr;
		end
	end

	// Dword for graphics, word for the rest
	assign word_end_nxt = (region_nxt == reg_gfx) ? &dl_addr[1:0] : dl_addr[0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			byte_vld    <= 1'b0;
			byte_region <= reg_none;
			byte_bank   <= '0;
		end else begin
			byte_vld <= accept;
			if (accept) begin
				byte_region <= region_nxt;
				byte_bank   <= bank_nxt;
			end
		end
	end

	// Payload follows the strobe
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			byte_addr <= dl_addr;
			byte_data <= dl_data;
			word_end  <= word_end_nxt;
		end
	end

	// Only six program banks exist downstream
	a_bank_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		byte_vld && (byte_region == reg_prog) |-> byte_bank < prog_bank_t'(PROG_BANKS));

endmodule

// File: design/word_packer.sv
// Second loader stage, gathers consecutive download bytes into one word of the region's width
`timescale 1ns/10ps

module word_packer #(
	parameter type word_t = logic [15:0]
) (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                byte_vld,	// From stage 1
	input  rom_word_pkg::byte_t byte_data,
	input  logic                word_end,
	input  logic                sel,		// Byte belongs to this packer's region
	output logic                word_vld,
	output word_t               word		// Oldest byte on top
);

	localparam int WW = $bits(word_t);

	// ########################################
	// Byte history
	// ########################################

	// Every accepted byte shifts in, whatever its region
	// so the word always ends with the latest byte
	always_ff @(posedge clk_sys) begin
		if (byte_vld) begin
			word <= {word[WW-9:0], byte_data};
		end
	end

	// ########################################
	// Completion strobe
	// ########################################

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			word_vld <= 1'b0;
		end else begin
			word_vld <= byte_vld && sel && word_end;	// Same edge as the last shift
		end
	end

	// Words end on odd addresses, so two in a row means a broken stream
	a_no_back_to_back: assert property (@(posedge clk_sys) disable iff (!arst_n)
		word_vld |=> !word_vld);

endmodule

// File: design/rom_bank.sv
// Dual port ROM bank, loader writes on one port and the game side reads on the other
`timescale 1ns/10ps

module rom_bank #(
	parameter type data_t = logic [7:0],
	parameter int  AW     = 14
) (
	input  logic          clk_sys,
	input  logic          wr,		// Loader write strobe
	input  logic [AW-1:0] wr_addr,
	input  data_t         wr_data,
	input  logic [AW-1:0] rd_addr,	// Game side
	output data_t         rd_data	// One cycle after rd_addr
);

	data_t mem [2**AW];	// Block RAM

	// Write port
	always_ff @(posedge clk_sys) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

	// Steering upstream must hand over a clean address with every write
	a_wr_addr_known: assert property (@(posedge clk_sys)
		wr |-> !$isunknown(wr_addr));

endmodule

// File: design/prog_rom.sv
// Main CPU program store, six interleaved ROM pairs behind one game side address space
`timescale 1ns/10ps

module prog_rom (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     wr,		// Word complete
	input  rom_map_pkg::prog_bank_t  wr_bank,
	input  rom_word_pkg::dl_addr_t   wr_addr,	// Byte address of the odd byte
	input  rom_word_pkg::prog_word_t wr_data,	// Even byte high
	input  rom_word_pkg::prog_addr_t rd_addr,
	output rom_word_pkg::prog_word_t rd_data
);
	import rom_word_pkg::*;
	import rom_map_pkg::*;

	localparam int PAW   = $bits(prog_addr_t);
	localparam int TOP_W = PAW - PROG_SEL_LSB;	// Window select bits

	logic [TOP_W-1:0]      rd_top_q;
	logic [PROG_BANKS-1:0] bank_hit;
	prog_word_t            bank_q [PROG_BANKS];

	// Select bits line up with the bank's registered data
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_top_q <= '0;
		end else begin
			rd_top_q <= rd_addr[PAW-1:PROG_SEL_LSB];
		end
	end

	// ########################################
	// Banks
	// ########################################

	for (genvar g = 0; g < PROG_BANKS; g++) begin : g_bank
		localparam int AW = PROG_BANK_AW[g];
		localparam int SH = AW - PROG_SEL_LSB;	// Select bits inside the bank
		localparam logic [TOP_W-1:0] WIN = PROG_GAME_BASE[g][PAW-1:PROG_SEL_LSB];

		logic bank_wr;

		assign bank_wr = wr && (wr_bank == prog_bank_t'(g));

		// Compare only the bits above the bank depth
		assign bank_hit[g] = (rd_top_q >> SH) == (WIN >> SH);

		rom_bank #(
			.data_t(prog_word_t),
			.AW    (AW)
		) u_bank (
			.clk_sys(clk_sys),
			.wr     (bank_wr),
			.wr_addr(wr_addr[AW:1]),	// Drop the byte lane bit
			.wr_data(wr_data),
			.rd_addr(rd_addr[AW-1:0]),
			.rd_data(bank_q[g])
		);
	end

	// ########################################
	// Read mux
	// ########################################

	always_comb begin
		rd_data = '0;	// Holes read as zero
		for (int b = 0; b < PROG_BANKS; b++) begin
			if (bank_hit[b]) begin
				rd_data = bank_q[b];
			end
		end
	end

endmodule

// File: design/sound_rom.sv
// Audio CPU ROM store, the 16S and 16R parts seen as one 64 KB space by the game side
`timescale 1ns/10ps

module sound_rom (
	input  logic                    clk_sys,
	input  logic                    wr,		// Registered region match
	input  rom_word_pkg::dl_addr_t  wr_addr,
	input  rom_word_pkg::byte_t     wr_data,
	input  rom_word_pkg::snd_addr_t rd_addr,
	output rom_word_pkg::byte_t     rd_data
);
	import rom_word_pkg::*;
	import rom_map_pkg::*;

	localparam int RD_SEL = $bits(snd_addr_t) - 1;	// Top bit picks the part

	logic  rd_s_q;	// Read select, aligned with bank data
	byte_t s_q;
	byte_t r_q;

	always_ff @(posedge clk_sys) begin
		rd_s_q <= rd_addr[RD_SEL];
	end

	// 16S at 0x140000, bit 15 clear in the download
	rom_bank #(
		.data_t(byte_t),
		.AW    (SND_S_AW)
	) u_16s (
		.clk_sys(clk_sys),
		.wr     (wr && !wr_addr[SND_S_AW]),
		.wr_addr(wr_addr[SND_S_AW-1:0]),
		.wr_data(wr_data),
		.rd_addr(rd_addr[SND_S_AW-1:0]),
		.rd_data(s_q)
	);

	// 16R at 0x148000
	rom_bank #(
		.data_t(byte_t),
		.AW    (SND_R_AW)
	) u_16r (
		.clk_sys(clk_sys),
		.wr     (wr && wr_addr[SND_S_AW]),
		.wr_addr(wr_addr[SND_R_AW-1:0]),
		.wr_data(wr_data),
		.rd_addr(rd_addr[SND_R_AW-1:0]),	// Mirrored in the lower half
		.rd_data(r_q)
	);

	assign rd_data = rd_s_q ? s_q : r_q;	// Upper half is 16S

endmodule

// File: design/rom_loader.sv
// ROM download path top level, host byte stream in, on-chip ROM reads and graphics writes out
`timescale 1ns/10ps

module rom_loader (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	// Host download
	input  logic                     dl_active,
	input  logic                     dl_wr,
	input  rom_word_pkg::dl_index_t  dl_index,
	input  rom_word_pkg::dl_addr_t   dl_addr,
	input  rom_word_pkg::byte_t      dl_data,
	// External graphics memory
	output logic                     gfx_wr,
	output rom_word_pkg::gfx_addr_t  gfx_addr,
	output rom_word_pkg::gfx_word_t  gfx_data,
	// Game side reads
	input  rom_word_pkg::prog_addr_t prog_rd_addr,
	output rom_word_pkg::prog_word_t prog_rd_data,
	input  rom_word_pkg::snd_addr_t  snd_rd_addr,
	output rom_word_pkg::byte_t      snd_rd_data,
	input  rom_word_pkg::chr_addr_t  chr_rd_addr,
	output rom_word_pkg::byte_t      chr_rd_data
);
	import rom_word_pkg::*;
	import rom_map_pkg::*;

	logic       byte_vld;
	region_t    byte_region;
	prog_bank_t byte_bank;
	dl_addr_t   byte_addr;
	byte_t      byte_data;
	logic       word_end;
	logic       gfx_sel;
	logic       prog_sel;
	logic       prog_vld;
	prog_word_t prog_word;
	logic       snd_wr_q;
	logic       chr_wr_q;
	prog_bank_t byte_bank_q;
	dl_addr_t   byte_addr_q;
	byte_t      byte_data_q;

	// ########################################
	// Stage 1, decode
	// ########################################

	load_decode u_decode (.*);

	assign gfx_sel  = (byte_region == reg_gfx);
	assign prog_sel = (byte_region == reg_prog);

	// ########################################
	// Stage 2, packing and byte delay
	// ########################################

	word_packer #(.word_t(gfx_word_t)) u_gfx_pack (
		.clk_sys(clk_sys), .arst_n(arst_n), .byte_vld(byte_vld), .byte_data(byte_data),
		.word_end(word_end), .sel(gfx_sel), .word_vld(gfx_wr), .word(gfx_data)
	);

	word_packer #(.word_t(prog_word_t)) u_prog_pack (
		.clk_sys(clk_sys), .arst_n(arst_n), .byte_vld(byte_vld), .byte_data(byte_data),
		.word_end(word_end), .sel(prog_sel), .word_vld(prog_vld), .word(prog_word)
	);

	// Byte stores and word addresses held one cycle to meet the packers
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			snd_wr_q <= 1'b0;
			chr_wr_q <= 1'b0;
		end else begin
			snd_wr_q <= byte_vld && (byte_region == reg_snd);
			chr_wr_q <= byte_vld && (byte_region == reg_chr);
		end
	end

	always_ff @(posedge clk_sys) begin
		byte_bank_q <= byte_bank;
		byte_addr_q <= byte_addr;
		byte_data_q <= byte_data;
	end

	assign gfx_addr = byte_addr_q[$bits(dl_addr_t)-1:2];	// Dword address

	// ########################################
	// Stage 3, ROM stores
	// ########################################

	prog_rom u_prog (
		.clk_sys(clk_sys), .arst_n(arst_n), .wr(prog_vld), .wr_bank(byte_bank_q),
		.wr_addr(byte_addr_q), .wr_data(prog_word), .rd_addr(prog_rd_addr),
		.rd_data(prog_rd_data)
	);

	sound_rom u_snd (
		.clk_sys(clk_sys), .wr(snd_wr_q), .wr_addr(byte_addr_q), .wr_data(byte_data_q),
		.rd_addr(snd_rd_addr), .rd_data(snd_rd_data)
	);

	rom_bank #(.data_t(byte_t), .AW(CHR_AW)) u_chr (	// 6P
		.clk_sys(clk_sys), .wr(chr_wr_q), .wr_addr(byte_addr_q[CHR_AW-1:0]),
		.wr_data(byte_data_q), .rd_addr(chr_rd_addr), .rd_data(chr_rd_data)
	);

endmodule

// File: tests/tb_clock.sv
// Testbench clock and power-on reset source, one instance in the testbench top
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 5
) (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Reset held over the first rising edges, released away from any edge
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		#(PERIOD_NS / 4) arst_n = 1'b1;
	end

endmodule

// File: tests/rom_loader_tb.sv
// ROM loader testbench, random download bursts checked against a byte model and ROM readback
`timescale 1ns/10ps

module rom_loader_tb;
	import rom_word_pkg::*;
	import rom_map_pkg::*;

	localparam int BURSTS      = 400;
	localparam int GFX_LATE    = 10;	// Cycles a graphics word may stay pending
	localparam int RST_TIMEOUT = 20;
	// Game side program holes, word addresses
	localparam int HOLE_BASE [3] = '{32'h08000, 32'h1C000, 32'h40000};
	localparam int HOLE_SIZE [3] = '{32'h10000, 32'h04000, 32'h40000};

	logic       clk_sys;
	logic       arst_n;
	logic       dl_active;
	logic       dl_wr;
	dl_index_t  dl_index;
	dl_addr_t   dl_addr;
	byte_t      dl_data;
	logic       gfx_wr;
	gfx_addr_t  gfx_addr;
	gfx_word_t  gfx_data;
	prog_addr_t prog_rd_addr;
	prog_word_t prog_rd_data;
	snd_addr_t  snd_rd_addr;
	byte_t      snd_rd_data;
	chr_addr_t  chr_rd_addr;
	byte_t      chr_rd_data;

	int         checks;
	int         errors;
	int         strobe_errors;
	int         timeouts;
	int         cycle;
	gfx_word_t  hist;			// Last four accepted bytes, newest low
	byte_t      dl_mem [int];		// Sound and character bytes by download address
	prog_word_t prog_mem [int];		// Program words by game side address
	gfx_addr_t  exp_addr [$];		// Pending graphics writes
	gfx_word_t  exp_data [$];
	int         exp_cyc [$];		// Cycle the word was sent

	tb_clock #(.PERIOD_NS(20), .RST_CYCLES(5)) u_clock (.clk_sys(clk_sys), .arst_n(arst_n));

	rom_loader UUT (.*);

	// ########################################
	// Compare tasks
	// ########################################

	task automatic check_gfx(string name, gfx_word_t exp, gfx_word_t act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0d ns: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_gfx_addr(string name, gfx_addr_t exp, gfx_addr_t act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0d ns: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_prog(string name, prog_word_t exp, prog_word_t act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0d ns: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_byte(string name, byte_t exp, byte_t act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0d ns: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// ########################################
	// Model and drivers
	// ########################################

	task automatic next_drive();
		@(posedge clk_sys);
		#2;	// Inputs change just after the edge
	endtask

	// Accepted byte, applies the board map
	task automatic model_byte(dl_addr_t a, byte_t d);
		hist = {hist[23:0], d};	// Oldest byte on top
		if (a < GFX_END && a[1:0] == 2'b11) begin
			exp_addr.push_back(a[24:2]);
			exp_data.push_back(hist);
			exp_cyc.push_back(cycle);
		end
		for (int b = 0; b < PROG_BANKS; b++) begin
			if (a[0] && a >= PROG_WIN_BASE[b]
					&& int'(a) < int'(PROG_WIN_BASE[b]) + (2 << PROG_BANK_AW[b])) begin
				prog_mem[int'(PROG_GAME_BASE[b]) + (int'(a - PROG_WIN_BASE[b]) >> 1)] = hist[15:0];
			end
		end
		if (a >= SND_S_BASE && int'(a) < int'(CHR_BASE) + 32'h4000) begin
			dl_mem[int'(a)] = d;	// 16S, 16R and character ROM
		end
	endtask

	task automatic send_byte(dl_addr_t a, byte_t d, logic ok);
		dl_wr     = 1'b1;
		dl_addr   = a;
		dl_data   = d;
		dl_active = 1'b1;
		dl_index  = '0;
		if (!ok) begin
			if ($urandom % 2) begin
				dl_active = 1'b0;
			end else begin
				dl_index = dl_index_t'(1 + $urandom % 32'hFFFF);	// Some other file
			end
		end else begin
			model_byte(a, d);
		end
		next_drive();
		dl_wr = 1'b0;
	endtask

	// One cycle reads, data sampled at the falling edge
	task automatic read_prog(prog_addr_t a, prog_word_t exp);
		prog_rd_addr = a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_prog("prog_rd_data", exp, prog_rd_data);
		next_drive();
	endtask

	task automatic read_snd(snd_addr_t a, byte_t exp);
		snd_rd_addr = a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_byte("snd_rd_data", exp, snd_rd_data);
		next_drive();
	endtask

	task automatic read_chr(chr_addr_t a, byte_t exp);
		chr_rd_addr = a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_byte("chr_rd_data", exp, chr_rd_data);
		next_drive();
	endtask

	// ########################################
	// Graphics write monitor
	// ########################################

	always @(negedge clk_sys) begin
		cycle++;
		if (arst_n && gfx_wr) begin
			if (exp_cyc.size() == 0) begin
				$display("Unexpected gfx_wr at %0d ns with no graphics word pending", $time);
				strobe_errors++;
			end else begin
				check_gfx_addr("gfx_addr", exp_addr.pop_front(), gfx_addr);
				check_gfx("gfx_data", exp_data.pop_front(), gfx_data);
				exp_cyc.delete(0);
			end
		end else if (exp_cyc.size() > 0 && cycle - exp_cyc[0] > GFX_LATE) begin
			$display("No gfx_wr within %0d cycles for graphics word address %h", GFX_LATE,
				exp_addr[0]);
			strobe_errors++;
			exp_addr.delete(0);
			exp_data.delete(0);
			exp_cyc.delete(0);
		end
	end

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		dl_addr_t start;
		int       len;
		int       gap;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		prog_rd_addr = '0;
		snd_rd_addr  = '0;
		chr_rd_addr  = '0;
		void'($urandom(15676));
		for (int i = 0; i < RST_TIMEOUT && arst_n !== 1'b1; i++) begin
			@(posedge clk_sys);
		end
		if (arst_n !== 1'b1) begin
			$display("Reset was never released");
			timeouts++;
		end
		next_drive();
		// Fill the packer history through a filler area
		for (int i = 0; i < 4; i++) begin
			send_byte(25'h0D0000 + dl_addr_t'(i), byte_t'($urandom), 1'b1);
		end
		for (int n = 0; n < BURSTS; n++) begin
			start = dl_addr_t'(($urandom % 32'h54000) << 2);	// Dword aligned
			len   = 4 + $urandom % 13;
			gap   = $urandom % 4;
			for (int i = 0; i < len; i++) begin
				send_byte(start + dl_addr_t'(i), byte_t'($urandom), ($urandom % 10) != 0);
			end
			repeat (gap) next_drive();
		end
		for (int i = 0; i < 4 * GFX_LATE && exp_cyc.size() > 0; i++) begin
			@(posedge clk_sys);
		end
		if (exp_cyc.size() > 0) begin
			$display("Timed out waiting for pending graphics writes");
			timeouts++;
		end
		repeat (4) next_drive();	// Last ROM writes land
		foreach (prog_mem[a]) begin
			read_prog(prog_addr_t'(a), prog_mem[a]);
		end
		for (int h = 0; h < 3; h++) begin
			for (int i = 0; i < 16; i++) begin
				read_prog(prog_addr_t'(HOLE_BASE[h] + $urandom % HOLE_SIZE[h]), '0);
			end
		end
		foreach (dl_mem[a]) begin
			if (a < int'(SND_R_BASE)) begin
				read_snd(snd_addr_t'(a - int'(SND_S_BASE)) | 16'h8000, dl_mem[a]);	// 16S
			end else if (a < int'(CHR_BASE)) begin
				read_snd(snd_addr_t'(a - int'(SND_R_BASE)), dl_mem[a]);
				read_snd(snd_addr_t'(a - int'(SND_R_BASE)) | 16'h4000, dl_mem[a]);	// Mirror
			end else begin
				read_chr(chr_addr_t'(a - int'(CHR_BASE)), dl_mem[a]);
			end
		end
		$display("Done: %0d checks, %0d mismatches, %0d strobe errors, %0d timeouts",
			checks, errors, strobe_errors, timeouts);
		if (errors + strobe_errors + timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: rom_loader.f
design/rom_word_pkg.sv
design/rom_map_pkg.sv
design/load_decode.sv
design/word_packer.sv
design/rom_bank.sv
design/prog_rom.sv
design/sound_rom.sv
design/rom_loader.sv
tests/tb_clock.sv
tests/rom_loader_tb.sv

// File: Makefile
# Verilator build and run of the ROM loader testbench

VERILATOR ?= verilator
TOP       ?= rom_loader_tb
FILELIST  ?= rom_loader.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= All tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
